//--- hdl/cpuPkg.sv
package cpuPkg;

	localparam int memWords = 2048;
	localparam int dataWidth = 16;
	localparam int addrWidth = $clog2(memWords);

	typedef logic [dataWidth-1:0] wordT;	// registers, memory, ports
	typedef logic [addrWidth-1:0] addrT;	// program/data address
	typedef logic [1:0] regSelT;

	// register codes as used in operand words
	localparam regSelT regAx = 2'd0;
	localparam regSelT regBx = 2'd1;
	localparam regSelT regCx = 2'd2;
	localparam regSelT regDx = 2'd3;

	typedef enum logic [15:0] {
		opNop  = 16'h00,
		opScf  = 16'h01,	// cf <= operand bit 0
		opCff  = 16'h02,
		opCof  = 16'h03,
		opCzf  = 16'h04,
		opMov3 = 16'h07,	// reg <= reg
		opMov4 = 16'h08,	// reg <= immediate
		opOut  = 16'h0A,
		opAdd  = 16'h0C,
		opAdc  = 16'h0D,
		opSub  = 16'h0E,
		opSuc  = 16'h0F,
		opCmp  = 16'h14,
		opAnd  = 16'h15,
		opNeg  = 16'h16,
		opNot  = 16'h17,
		opOr   = 16'h18,
		opShl  = 16'h19,
		opShr  = 16'h1A,
		opXor  = 16'h1B,
		opTest = 16'h1C,
		opJmp  = 16'h20,
		opJc   = 16'h21,
		opJnc  = 16'h22,
		opJz   = 16'h23,
		opJnz  = 16'h24,
		opJo   = 16'h25,
		opJno  = 16'h26,
		opIn   = 16'h28,
		opXch  = 16'h29,
		opMov5 = 16'h2A,	// mem[addr] <= reg
		opMov6 = 16'h2B		// reg <= mem[addr]
	} opcodeT;

	typedef enum logic [4:0] {
		aluAdd = 5'h01,
		aluAdc = 5'h02,
		aluSub = 5'h03,
		aluSuc = 5'h04,
		aluAnd = 5'h05,
		aluOr  = 5'h06,
		aluXor = 5'h07,
		aluNot = 5'h08,
		aluNeg = 5'h09,
		aluShl = 5'h0A,
		aluShr = 5'h0B
	} aluOpT;

	typedef enum logic {sExec, sAluWait} ctrlStateT;

endpackage

//--- hdl/progMemory.sv
`timescale 1ns/10ps

module progMemory (
	input  logic         clk,
	input  logic         reset,
	input  logic         loadEn,
	input  cpuPkg::addrT loadAddr,
	input  cpuPkg::wordT loadData,
	input  cpuPkg::addrT pc,
	output cpuPkg::wordT fetch0,
	output cpuPkg::wordT fetch1,
	output cpuPkg::wordT fetch2,
	input  cpuPkg::addrT memAddr,
	output cpuPkg::wordT rdData,
	input  logic         memWe,
	input  cpuPkg::wordT memWdata
);
	import cpuPkg::*;

	wordT mem [memWords];	// program and data share this array

	// operand fetch wraps at the top of memory
	assign fetch0 = mem[pc];
	assign fetch1 = mem[pc + addrT'(1)];
	assign fetch2 = mem[pc + addrT'(2)];
	assign rdData = mem[memAddr];

	always_ff @(posedge clk) begin
		if (!reset) begin
			if (loadEn)
				mem[loadAddr] <= loadData;	// program load while core is held
		end else if (memWe) begin
			mem[memAddr] <= memWdata;	// MOV5 store
		end
	end

	// the control unit stays quiet on the core port during load
	assert property (@(posedge clk) !reset |-> !memWe)
		else $error("core memory write while in reset");

endmodule

//--- hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic           clk,
	input  logic           reset,
	input  logic           wrEn,
	input  cpuPkg::regSelT wrSel,
	input  cpuPkg::wordT   wrData,
	input  logic           xchEn,
	input  cpuPkg::regSelT selA,
	input  cpuPkg::regSelT selB,
	output cpuPkg::wordT   rdA,
	output cpuPkg::wordT   rdB,
	output cpuPkg::wordT   base,
	output cpuPkg::wordT   data
);
	import cpuPkg::*;

	wordT regs [4];	// ax, bx, cx, dx

	assign rdA = regs[selA];
	assign rdB = regs[selB];

	// port address and data always follow bx and dx
	assign base = regs[regBx];
	assign data = regs[regDx];

	always_ff @(posedge clk) begin
		if (!reset) begin
			regs <= '{default: '0};
		end else if (xchEn) begin
			regs[selA] <= rdB;	// swap in one edge
			regs[selB] <= rdA;
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	// decode never asks for a write and a swap together
	assert property (@(posedge clk) disable iff (!reset) !(wrEn && xchEn))
		else $error("register write and exchange in the same cycle");

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
	input  logic          clk,
	input  logic          reset,
	input  logic          aluIssue,
	input  cpuPkg::aluOpT aluOp,
	input  cpuPkg::wordT  aluA,
	input  cpuPkg::wordT  aluB,
	input  logic          carryIn,
	output cpuPkg::wordT  result,
	output logic          cOut,
	output logic          zOut,
	output logic          oOut
);
	import cpuPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth:0] sum;	// extra bit holds carry or borrow
	wordT res;
	logic cin;
	logic c;
	logic o;

	assign cin = (aluOp == aluAdc || aluOp == aluSuc) ? carryIn : 1'b0;

	always_comb begin
		sum = '0;
		res = '0;
		c = carryIn;	// unchanged unless the op defines it
		o = 1'b0;
		case (aluOp)
			aluAdd, aluAdc: begin
				sum = {1'b0, aluA} + {1'b0, aluB} + {{dataWidth{1'b0}}, cin};
				res = sum[msb:0];
				c = sum[dataWidth];
				o = (aluA[msb] == aluB[msb]) && (res[msb] != aluA[msb]);
			end
			aluSub, aluSuc: begin
				sum = {1'b0, aluA} - {1'b0, aluB} - {{dataWidth{1'b0}}, cin};
				res = sum[msb:0];
				c = sum[dataWidth];	// borrow
				o = (aluA[msb] != aluB[msb]) && (res[msb] != aluA[msb]);
			end
			aluAnd: res = aluA & aluB;
			aluOr:  res = aluA | aluB;
			aluXor: res = aluA ^ aluB;
			aluNot: res = ~aluA;
			aluNeg: res = wordT'(0) - aluA;
			aluShl: begin
				res = {aluA[msb-1:0], 1'b0};
				c = aluA[msb];
			end
			aluShr: begin
				res = {1'b0, aluA[msb:1]};
				c = aluA[0];
			end
			default: res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (aluIssue)
			result <= res;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			cOut <= 1'b0;
			zOut <= 1'b0;
			oOut <= 1'b0;
		end else if (aluIssue) begin
			cOut <= c;
			zOut <= (res == '0);
			oOut <= o;
		end
	end

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::wordT    fetch0,
	input  cpuPkg::wordT    fetch1,
	input  cpuPkg::wordT    fetch2,
	input  cpuPkg::wordT    rdData,
	input  cpuPkg::wordT    portIn,
	output cpuPkg::addrT    pc,
	output cpuPkg::addrT    memAddr,
	output logic            memWe,
	output cpuPkg::wordT    memWdata,
	output logic            wrEn,
	output cpuPkg::regSelT  wrSel,
	output cpuPkg::wordT    wrData,
	output logic            xchEn,
	output cpuPkg::regSelT  selA,
	output cpuPkg::regSelT  selB,
	input  cpuPkg::wordT    rdA,
	input  cpuPkg::wordT    rdB,
	output logic            aluIssue,
	output cpuPkg::aluOpT   aluOp,
	output cpuPkg::wordT    aluA,
	output cpuPkg::wordT    aluB,
	output logic            carryIn,
	input  cpuPkg::wordT    result,
	input  logic            cOut,
	input  logic            zOut,
	input  logic            oOut,
	output logic            outStrobe
);
	import cpuPkg::*;

	ctrlStateT state, stateNext;
	opcodeT opcode;
	addrT pcNext;
	addrT target;
	logic cf, zf, of;
	logic cfNext, zfNext, ofNext;
	logic outPulse;
	logic isAlu, aluWb, setC, setO;
	regSelT aluDst;
	addrT aluLen;
	regSelT dstSel, srcSel;

	function automatic aluOpT aluOpFor(opcodeT op);
		case (op)
			opAdc:   aluOpFor = aluAdc;
			opSub:   aluOpFor = aluSub;
			opSuc:   aluOpFor = aluSuc;
			opCmp:   aluOpFor = aluSub;	// flags only
			opAnd:   aluOpFor = aluAnd;
			opTest:  aluOpFor = aluAnd;
			opOr:    aluOpFor = aluOr;
			opXor:   aluOpFor = aluXor;
			opNot:   aluOpFor = aluNot;
			opNeg:   aluOpFor = aluNeg;
			opShl:   aluOpFor = aluShl;
			opShr:   aluOpFor = aluShr;
			default: aluOpFor = aluAdd;
		endcase
	endfunction

	assign opcode = opcodeT'(fetch0);
	assign dstSel = fetch1[3:2];
	assign srcSel = fetch1[1:0];
	assign target = addrT'(fetch1);	// jumps and MOV5 address
	assign aluA = rdA;
	assign aluB = rdB;
	assign carryIn = cf;
	assign memWdata = rdB;
	assign aluOp = aluOpFor(opcode);

	always_comb begin
		pcNext = pc;
		stateNext = state;
		cfNext = cf;
		zfNext = zf;
		ofNext = of;
		wrEn = 1'b0;
		wrSel = dstSel;
		wrData = rdB;
		xchEn = 1'b0;
		selA = dstSel;
		selB = srcSel;
		memWe = 1'b0;
		memAddr = target;
		aluIssue = 1'b0;
		outPulse = 1'b0;
		isAlu = 1'b0;
		aluWb = 1'b1;
		aluDst = dstSel;
		aluLen = addrT'(1);
		setC = 1'b0;
		setO = 1'b0;
		if (reset) begin	// core held while memory loads
			case (opcode)
				opScf: begin
					cfNext = fetch1[0];
					pcNext = pc + addrT'(2);
				end
				opCff, opCof, opCzf: begin	// flag copy into dx
					wrEn = 1'b1;
					wrSel = regDx;
					wrData = wordT'(opcode == opCff ? cf : (opcode == opCof ? of : zf));
					pcNext = pc + addrT'(1);
				end
				opMov3: begin
					wrEn = 1'b1;
					pcNext = pc + addrT'(2);
				end
				opMov4: begin
					wrEn = 1'b1;
					wrSel = srcSel;
					wrData = fetch2;
					pcNext = pc + addrT'(3);
				end
				opMov5: begin
					selB = fetch2[1:0];
					memWe = 1'b1;
					pcNext = pc + addrT'(3);
				end
				opMov6: begin
					memAddr = addrT'(fetch2);
					wrEn = 1'b1;
					wrSel = srcSel;
					wrData = rdData;
					pcNext = pc + addrT'(3);
				end
				opXch: begin
					xchEn = 1'b1;
					pcNext = pc + addrT'(2);
				end
				opIn: begin
					wrEn = 1'b1;
					wrSel = regDx;
					wrData = portIn;
					pcNext = pc + addrT'(1);
				end
				opOut: begin
					if (!outStrobe) begin	// back-to-back OUT waits a cycle
						outPulse = 1'b1;
						pcNext = pc + addrT'(1);
					end
				end
				opAdd, opAdc, opSub, opSuc, opCmp: begin	// dx op ax
					isAlu = 1'b1;
					selA = regDx;
					selB = regAx;
					aluDst = regAx;
					aluWb = (opcode != opCmp);
					setC = 1'b1;
					setO = 1'b1;
				end
				opAnd, opOr, opXor, opTest: begin
					isAlu = 1'b1;
					aluLen = addrT'(2);
					aluWb = (opcode != opTest);
				end
				opNot, opNeg, opShl, opShr: begin	// single operand in bits 1:0
					isAlu = 1'b1;
					aluLen = addrT'(2);
					selA = srcSel;
					aluDst = srcSel;
					setC = (opcode == opShl || opcode == opShr);
				end
				opJmp: pcNext = target;
				opJc:  pcNext = cf ? target : pc + addrT'(2);
				opJnc: pcNext = !cf ? target : pc + addrT'(2);
				opJz:  pcNext = zf ? target : pc + addrT'(2);
				opJnz: pcNext = !zf ? target : pc + addrT'(2);
				opJo:  pcNext = of ? target : pc + addrT'(2);
				opJno: pcNext = !of ? target : pc + addrT'(2);
				default: pcNext = pc + addrT'(1);	// NOP and unknown codes
			endcase
			if (isAlu) begin
				if (state == sExec) begin
					aluIssue = 1'b1;	// pc holds for the wait cycle
					stateNext = sAluWait;
				end else begin
					wrEn = aluWb;
					wrSel = aluDst;
					wrData = result;
					zfNext = zOut;
					if (setC)
						cfNext = cOut;
					if (setO)
						ofNext = oOut;
					pcNext = pc + aluLen;
					stateNext = sExec;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			state <= sExec;
			cf <= 1'b0;
			zf <= 1'b0;
			of <= 1'b0;
			outStrobe <= 1'b0;
		end else begin
			pc <= pcNext;
			state <= stateNext;
			cf <= cfNext;
			zf <= zfNext;
			of <= ofNext;
			outStrobe <= outPulse;
		end
	end

	// issue is always followed by exactly one write-back cycle
	assert property (@(posedge clk) disable iff (!reset)
		aluIssue |-> state == sExec ##1 (state == sAluWait && !aluIssue))
		else $error("ALU issue outside sExec");

	assert property (@(posedge clk) disable iff (!reset) outStrobe |=> !outStrobe)
		else $error("OUT strobe held for two cycles");

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
	input  logic           clk,
	input  logic           reset,
	input  logic           loadEn,
	input  cpuPkg::addrT   loadAddr,
	input  cpuPkg::wordT   loadData,
	input  cpuPkg::wordT   portIn,
	output cpuPkg::wordT   base,
	output cpuPkg::wordT   data,
	output logic           outStrobe
);
	import cpuPkg::*;

	addrT pc;
	wordT fetch0;
	wordT fetch1;
	wordT fetch2;
	addrT memAddr;
	wordT rdData;
	logic memWe;
	wordT memWdata;

	logic wrEn;
	regSelT wrSel;
	wordT wrData;
	logic xchEn;
	regSelT selA;
	regSelT selB;
	wordT rdA;
	wordT rdB;

	logic aluIssue;
	aluOpT aluOp;
	wordT aluA;
	wordT aluB;
	logic carryIn;
	wordT result;
	logic cOut;
	logic zOut;
	logic oOut;

	progMemory iMem (
		.clk, .reset, .loadEn, .loadAddr, .loadData,
		.pc, .fetch0, .fetch1, .fetch2,
		.memAddr, .rdData, .memWe, .memWdata
	);

	controlUnit iCtrl (
		.clk, .reset, .fetch0, .fetch1, .fetch2, .rdData, .portIn,
		.pc, .memAddr, .memWe, .memWdata,
		.wrEn, .wrSel, .wrData, .xchEn, .selA, .selB, .rdA, .rdB,
		.aluIssue, .aluOp, .aluA, .aluB, .carryIn,
		.result, .cOut, .zOut, .oOut,
		.outStrobe
	);

	regFile iRegs (
		.clk, .reset, .wrEn, .wrSel, .wrData, .xchEn,
		.selA, .selB, .rdA, .rdB, .base, .data
	);

	aluUnit iAlu (
		.clk, .reset, .aluIssue, .aluOp, .aluA, .aluB, .carryIn,
		.result, .cOut, .zOut, .oOut
	);

endmodule

//--- verif/cpuPrograms.svh
localparam int nRows = 8;
localparam int progMax = 64;
localparam int maxOut = 4;	// OUT pairs per row

wordT prog [nRows][progMax];
int progLen [nRows];
wordT portVal [nRows];	// portIn seen by IN
wordT expBase [nRows][maxOut];
wordT expData [nRows][maxOut];
int outCount [nRows];

function automatic wordT pair(input regSelT dst, input regSelT src);
	pair = {12'd0, dst, src};	// dst in 3:2, src in 1:0
endfunction

// target just past a jump and the single one-word instruction after it
function automatic wordT pastNextWord(input int r);
	pastNextWord = wordT'(progLen[r] + 3);
endfunction

task automatic emit1(input int r, input wordT w);
	prog[r][progLen[r]] = w;
	progLen[r]++;
endtask

task automatic emit2(input int r, input wordT op, input wordT w);
	emit1(r, op);
	emit1(r, w);
endtask

task automatic emit3(input int r, input wordT op, input wordT w1, input wordT w2);
	emit2(r, op, w1);
	emit1(r, w2);
endtask

task automatic recordOut(input int r, input wordT b, input wordT d);
	expBase[r][outCount[r]] = b;
	expData[r][outCount[r]] = d;
	outCount[r]++;
endtask

task automatic expectOut(input int r, input wordT b, input wordT d);
	emit1(r, opOut);
	recordOut(r, b, d);
endtask

task automatic buildTable();
	wordT a;
	wordT d;
	wordT x;
	wordT s;
	logic c;
	logic o;
	int t;
	int n;
	int loopTop;
	for (int r = 0; r < nRows; r++) begin
		progLen[r] = 0;
		outCount[r] = 0;
		portVal[r] = wordT'($urandom);
	end
	a = wordT'($urandom);
	d = wordT'($urandom);
	x = wordT'($urandom);
	// row 0 immediates, moves and exchange
	emit3(0, opMov4, regBx, a);
	emit3(0, opMov4, regDx, d);
	expectOut(0, a, d);
	emit2(0, opXch, pair(regBx, regDx));
	expectOut(0, d, a);
	emit3(0, opMov4, regAx, x);
	emit2(0, opMov3, pair(regDx, regAx));
	expectOut(0, d, x);
	emit2(0, opMov3, pair(regCx, regBx));
	emit2(0, opXch, pair(regCx, regDx));	// dx takes old bx
	expectOut(0, d, d);
	// row 1 ADD then ADC with flag copies
	emit3(1, opMov4, regAx, a);
	emit3(1, opMov4, regDx, d);
	emit1(1, opAdd);
	emit2(1, opMov3, pair(regBx, regAx));
	{c, s} = {1'b0, d} + {1'b0, a};
	t = $signed(d) + $signed(a);
	o = (t > 32767) || (t < -32768);
	emit1(1, opCof);
	expectOut(1, s, o);
	emit1(1, opCzf);
	expectOut(1, s, s == 16'd0);
	emit1(1, opCff);
	expectOut(1, s, c);
	emit3(1, opMov4, regDx, x);
	emit1(1, opAdc);
	emit2(1, opMov3, pair(regBx, regAx));
	{c, s} = {1'b0, x} + {1'b0, s} + 17'(c);
	emit1(1, opCff);
	expectOut(1, s, c);
	// row 2 SUB, SUC and CMP
	emit3(2, opMov4, regAx, a);
	emit3(2, opMov4, regDx, d);
	emit1(2, opSub);
	emit2(2, opMov3, pair(regBx, regAx));
	s = d - a;
	c = d < a;	// borrow
	emit1(2, opCff);
	expectOut(2, s, c);
	emit3(2, opMov4, regDx, d);
	emit1(2, opSuc);
	emit2(2, opMov3, pair(regBx, regAx));
	t = $signed(d) - $signed(s);
	t = t - c;
	o = (t > 32767) || (t < -32768);
	s = d - s - wordT'(c);
	emit1(2, opCof);
	expectOut(2, s, o);
	emit3(2, opMov4, regAx, a);
	emit3(2, opMov4, regDx, x);
	emit1(2, opCmp);
	emit2(2, opMov3, pair(regBx, regAx));	// ax must be untouched
	emit1(2, opCzf);
	expectOut(2, a, x == a);
	emit3(2, opMov4, regDx, a);
	emit1(2, opCmp);
	emit1(2, opCzf);
	expectOut(2, a, 16'd1);
	// row 3 TEST, AND, OR and XOR
	emit3(3, opMov4, regBx, a);
	emit3(3, opMov4, regDx, d);
	emit3(3, opMov4, regCx, d);
	emit2(3, opTest, pair(regBx, regDx));
	expectOut(3, a, d);
	emit1(3, opCzf);
	expectOut(3, a, (a & d) == 16'd0);
	emit2(3, opAnd, pair(regBx, regCx));
	emit3(3, opMov4, regDx, x);
	emit2(3, opOr, pair(regBx, regDx));
	emit2(3, opXor, pair(regDx, regCx));
	expectOut(3, (a & d) | x, x ^ d);
	emit2(3, opXor, pair(regCx, regCx));	// zero result
	emit1(3, opCzf);
	expectOut(3, (a & d) | x, 16'd1);
	// row 4 NOT, NEG and the shifts
	emit3(4, opMov4, regBx, a);
	emit3(4, opMov4, regDx, d);
	emit2(4, opNot, regBx);
	emit2(4, opShl, regDx);
	expectOut(4, ~a, d << 1);
	emit1(4, opCff);
	expectOut(4, ~a, d[15]);
	emit2(4, opNeg, regBx);
	emit3(4, opMov4, regDx, d);
	emit2(4, opShr, regDx);
	expectOut(4, wordT'(-(~a)), d >> 1);
	emit1(4, opCff);
	expectOut(4, wordT'(-(~a)), d[0]);
	// row 5 store, load back and port input
	emit3(5, opMov4, regBx, a);
	emit3(5, opMov5, 16'h0400, regBx);
	emit3(5, opMov4, regBx, x);
	emit3(5, opMov6, regDx, 16'h0400);
	expectOut(5, x, a);
	emit1(5, opIn);
	expectOut(5, x, portVal[5]);
	emit3(5, opMov5, 16'h0401, regDx);
	emit3(5, opMov6, regBx, 16'h0401);
	expectOut(5, portVal[5], portVal[5]);
	// row 6 conditional jumps, each taken one skips a CFF that would spoil dx
	emit3(6, opMov4, regBx, 16'h0001);
	emit2(6, opScf, 16'h0001);
	emit2(6, opJc, pastNextWord(6));
	emit1(6, opCff);
	emit2(6, opJnc, pastNextWord(6));
	expectOut(6, 16'h0001, 16'h0000);
	emit2(6, opScf, 16'h0000);
	emit3(6, opMov4, regDx, 16'h0002);
	emit2(6, opJnc, pastNextWord(6));
	emit1(6, opCff);
	emit2(6, opJc, pastNextWord(6));
	expectOut(6, 16'h0001, 16'h0002);
	emit3(6, opMov4, regAx, 16'h0003);
	emit3(6, opMov4, regDx, 16'h0003);
	emit1(6, opCmp);	// equal, so zf set
	emit2(6, opJz, pastNextWord(6));
	emit1(6, opCff);
	emit2(6, opJnz, pastNextWord(6));
	expectOut(6, 16'h0001, 16'h0003);
	emit3(6, opMov4, regDx, 16'h8000);
	emit3(6, opMov4, regAx, 16'h0001);
	emit1(6, opCmp);	// most negative minus one overflows
	emit2(6, opJo, pastNextWord(6));
	emit1(6, opCff);
	emit2(6, opJno, pastNextWord(6));
	expectOut(6, 16'h0001, 16'h8000);
	// row 7 countdown loop closed by JNZ
	n = $urandom_range(3, 2);
	emit3(7, opMov4, regBx, 16'h0077);
	emit3(7, opMov4, regDx, wordT'(n));
	loopTop = progLen[7];
	emit1(7, opOut);
	emit3(7, opMov4, regAx, 16'h0001);
	emit1(7, opSub);
	emit2(7, opMov3, pair(regDx, regAx));
	emit2(7, opJnz, wordT'(loopTop));
	for (int k = n; k > 0; k--)
		recordOut(7, 16'h0077, wordT'(k));
	emit3(7, opMov4, regBx, 16'h0099);
	expectOut(7, 16'h0099, 16'h0000);
	for (int r = 0; r < nRows; r++)
		emit2(r, opJmp, wordT'(progLen[r]));	// park on itself
endtask

//--- verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;
	import cpuPkg::*;

	localparam int strobeTimeout = 500;	// cycles allowed between OUT strobes
	localparam int minResetCycles = 5;

	logic clk;
	logic reset;
	logic loadEn;
	addrT loadAddr;
	wordT loadData;
	wordT portIn;
	wordT base;
	wordT data;
	logic outStrobe;
	int errorCount;

	`include "cpuPrograms.svh"

	cpuTop i_dut (
		.clk,
		.reset,
		.loadEn,
		.loadAddr,
		.loadData,
		.portIn,
		.base,
		.data,
		.outStrobe
	);

	always #4 clk = ~clk;	// 8 ns period

	task automatic failRun();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input wordT got, input wordT want);
		if (got !== want) begin
			errorCount++;
			$display("[FAIL] %s: got %h, expected %h", name, got, want);
			failRun();
		end
	endtask

	// holds the core in reset while the program goes in through the load port
	task automatic loadRow(input int r);
		int cycles;
		cycles = (progLen[r] > minResetCycles) ? progLen[r] : minResetCycles;
		reset = 1'b0;
		portIn = portVal[r];
		for (int i = 0; i < cycles; i++) begin
			loadEn = (i < progLen[r]);
			loadAddr = addrT'(i);
			loadData = prog[r][i];
			@(posedge clk);
			#1;
		end
		loadEn = 1'b0;
		reset = 1'b1;
	endtask

	// sampled on the falling edge, mid-cycle
	task automatic waitStrobe(input int r, input int k);
		int t;
		t = 0;
		@(negedge clk);
		while (!outStrobe && t < strobeTimeout) begin
			@(negedge clk);
			t++;
		end
		if (!outStrobe) begin
			$display("timed out in row %0d waiting for OUT strobe number %0d", r, k);
			failRun();
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		portIn = '0;
		errorCount = 0;
		void'($urandom(50));
		buildTable();
		for (int r = 0; r < nRows; r++) begin
			@(posedge clk);
			#1;
			loadRow(r);
			for (int k = 0; k < outCount[r]; k++) begin
				waitStrobe(r, k);
				checkValue("base", base, expBase[r][k]);
				checkValue("data", data, expData[r][k]);
			end
		end
		if (errorCount == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			failRun();
		end
	end

endmodule

//--- list.f
+incdir+verif
hdl/cpuPkg.sv
hdl/progMemory.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/controlUnit.sv
hdl/cpuTop.sv
verif/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - hdl/cpuPkg.sv
  - hdl/progMemory.sv
  - hdl/regFile.sv
  - hdl/aluUnit.sv
  - hdl/controlUnit.sv
  - hdl/cpuTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/cpuTb.sv
